// ==== Makefile ====
# Verilator build and run of the vector coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_top
FLAGS     ?= --assert
FILELIST  ?= project.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== project.f ====
src/vec_pkg.sv
src/vec_dispatcher.sv
src/vec_lane.sv
src/vec_mask_unit.sv
src/vec_top.sv
tb/tb_vec_top.sv

// ==== src/vec_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; #(
  parameter  int unsigned NrLanes   = 4,
  parameter  int unsigned VLenElems = 16,
  localparam int unsigned NrRows    = VLenElems / NrLanes,
  localparam int unsigned RowWidth  = (NrRows > 1) ? $clog2(NrRows) : 1,
  localparam int unsigned LaneWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1,
  localparam int unsigned IdxWidth  = (VLenElems > 1) ? $clog2(VLenElems) : 1
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Core port
  input  acc_req_t                  acc_req_i,
  input  logic                      acc_req_valid_i,
  output logic                      acc_req_ready_o,
  output acc_resp_t                 acc_resp_o,
  output logic                      acc_resp_valid_o,
  input  logic                      acc_resp_ready_i,
  // To the lanes and the mask unit
  output lane_cmd_t                 lane_cmd_o,
  output logic       [RowWidth-1:0] row_o,
  output logic                      issue_o,
  // From the lanes
  input  elem_t      [NrLanes-1:0]  lane_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_RESP
  } state_e;

  state_e               state_q;
  acc_req_t             req_q;
  acc_resp_t            resp_q;
  logic [RowWidth-1:0]  row_q;
  logic [LaneWidth-1:0] lane_sel_q;
  logic [IdxWidth-1:0]  xs_idx;
  logic                 legal;
  logic                 single_row;
  logic                 last_row;

  // Element index of a scalar move, wrapped into the vector
  assign xs_idx = IdxWidth'(acc_req_i.scalar % VLenElems);

  assign legal      = op_is_legal(req_q.op);
  assign single_row = !legal || (req_q.op == OP_VMV_XS);
  assign last_row   = single_row || (row_q == RowWidth'(NrRows - 1));

  assign acc_req_ready_o  = (state_q == ST_IDLE);
  assign acc_resp_valid_o = (state_q == ST_RESP);
  assign acc_resp_o       = resp_q;

  // Illegal opcodes wait one cycle without touching the datapath
  assign issue_o = (state_q == ST_ISSUE) && legal;
  assign row_o   = row_q;

  assign lane_cmd_o.op     = req_q.op;
  assign lane_cmd_o.vd     = req_q.vd;
  assign lane_cmd_o.vs1    = req_q.vs1;
  assign lane_cmd_o.vs2    = req_q.vs2;
  assign lane_cmd_o.vm     = req_q.vm;
  assign lane_cmd_o.scalar = req_q.scalar;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      row_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (acc_req_valid_i) begin
            state_q <= ST_ISSUE;
            // Scalar move only visits the row holding its element
            row_q   <= (acc_req_i.op == OP_VMV_XS) ? RowWidth'(xs_idx / NrLanes) : '0;
          end
        end
        ST_ISSUE: begin
          if (last_row) begin
            state_q <= ST_RESP;
          end else begin
            row_q <= row_q + RowWidth'(1);
          end
        end
        ST_RESP: begin
          if (acc_resp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Request and response data
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (acc_req_valid_i && acc_req_ready_o) begin
      req_q      <= acc_req_i;
      lane_sel_q <= LaneWidth'(xs_idx % NrLanes);
    end
    if ((state_q == ST_ISSUE) && last_row) begin
      resp_q.data  <= (req_q.op == OP_VMV_XS) ? lane_rdata_i[lane_sel_q] : '0;
      resp_q.error <= !legal;
    end
  end

  // Held response must not change under back-pressure
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o));

endmodule : vec_dispatcher

`default_nettype wire

// ==== src/vec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; #(
  parameter  int unsigned NrLanes   = 4,
  parameter  int unsigned VLenElems = 16,
  parameter  int unsigned LaneId    = 0,
  localparam int unsigned NrRows    = VLenElems / NrLanes,
  localparam int unsigned RowWidth  = (NrRows > 1) ? $clog2(NrRows) : 1
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // From the dispatcher
  input  lane_cmd_t                lane_cmd_i,
  input  logic      [RowWidth-1:0] row_i,
  input  logic                     issue_i,
  // From the mask unit
  input  logic                     mask_bit_i,
  // Results
  output logic                     cmp_o,
  output elem_t                    rdata_o
);

  // Register file slice, one element per register and row
  elem_t vrf_q [NrVRegs][NrRows];

  elem_t vs1_data;
  elem_t vs2_data;
  elem_t wdata;
  logic  writes_vd;
  logic  masked_off;
  logic  we;

  //////////////////////////////
  // Operand read
  //////////////////////////////

  assign vs1_data = vrf_q[lane_cmd_i.vs1][row_i];
  assign vs2_data = vrf_q[lane_cmd_i.vs2][row_i];

  assign rdata_o = vs2_data;
  assign cmp_o   = (vs2_data == vs1_data);

  //////////////////////////////
  // Integer ALU
  //////////////////////////////

  always_comb begin
    wdata     = '0;
    writes_vd = 1'b1;
    case (lane_cmd_i.op)
      OP_VMV_VX: wdata = lane_cmd_i.scalar;
      // Global element index of this slot
      OP_VID:    wdata = elem_t'(row_i) * elem_t'(NrLanes) + elem_t'(LaneId);
      OP_VADD:   wdata = vs2_data + vs1_data;
      OP_VSUB:   wdata = vs2_data - vs1_data;
      OP_VAND:   wdata = vs2_data & vs1_data;
      default:   writes_vd = 1'b0;
    endcase
  end

  // Masked-off elements keep their old value
  assign masked_off = lane_cmd_i.vm && !mask_bit_i;
  assign we         = issue_i && writes_vd && !masked_off;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int e = 0; e < NrRows; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (we) begin
      vrf_q[lane_cmd_i.vd][row_i] <= wdata;
    end
  end

  // Dispatcher filters illegal opcodes before they reach a lane
  a_issue_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_i |-> op_is_legal(lane_cmd_i.op));

endmodule : vec_lane

`default_nettype wire

// ==== src/vec_mask_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_mask_unit import vec_pkg::*; #(
  parameter  int unsigned NrLanes   = 4,
  parameter  int unsigned VLenElems = 16,
  localparam int unsigned NrRows    = VLenElems / NrLanes,
  localparam int unsigned RowWidth  = (NrRows > 1) ? $clog2(NrRows) : 1
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // From the dispatcher
  input  lane_cmd_t                lane_cmd_i,
  input  logic      [RowWidth-1:0] row_i,
  input  logic                     issue_i,
  // Compare bits from the lanes
  input  logic      [NrLanes-1:0]  cmp_i,
  // Mask bits for the current row
  output logic      [NrLanes-1:0]  mask_bits_o
);

  // One bit per element, grouped by row
  logic [NrRows-1:0][NrLanes-1:0] mask_q;
  logic                           cmp_wr;

  // The compare writes every element, vm plays no part here
  assign cmp_wr = issue_i && (lane_cmd_i.op == OP_VMSEQ);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q <= '0;
    end else if (cmp_wr) begin
      mask_q[row_i] <= cmp_i;
    end
  end

  // Combinational from the register, so a write is visible on the next row
  assign mask_bits_o = mask_q[row_i];

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Row counter of the dispatcher stays inside the register file
  a_row_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_i |-> (row_i < NrRows));

endmodule : vec_mask_unit

`default_nettype wire

// ==== src/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]       elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // Codes 4'h7 and above are illegal
  typedef enum logic [3:0] {
    OP_VMV_VX = 4'h0,
    OP_VID    = 4'h1,
    OP_VADD   = 4'h2,
    OP_VSUB   = 4'h3,
    OP_VAND   = 4'h4,
    OP_VMSEQ  = 4'h5,
    OP_VMV_XS = 4'h6
  } vec_op_e;

  // Request from the scalar core
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    logic    vm;
    elem_t   scalar;
  } acc_req_t;

  typedef struct packed {
    elem_t data;
    logic  error;
  } acc_resp_t;

  // Broadcast to every lane and to the mask unit
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    logic    vm;
    elem_t   scalar;
  } lane_cmd_t;

  function automatic logic op_is_legal(vec_op_e op);
    case (op)
      OP_VMV_VX, OP_VID, OP_VADD, OP_VSUB, OP_VAND, OP_VMSEQ, OP_VMV_XS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage : vec_pkg

`default_nettype wire

// ==== src/vec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; #(
  parameter  int unsigned NrLanes   = 4,
  parameter  int unsigned VLenElems = 16,
  localparam int unsigned NrRows    = VLenElems / NrLanes,
  localparam int unsigned RowWidth  = (NrRows > 1) ? $clog2(NrRows) : 1
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Core port
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  lane_cmd_t                   lane_cmd;
  logic      [RowWidth-1:0]    row;
  logic                        issue;
  elem_t     [NrLanes-1:0]     lane_rdata;
  logic      [NrLanes-1:0]     cmp;
  logic      [NrLanes-1:0]     mask_bits;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  vec_dispatcher #(
    .NrLanes  (NrLanes  ),
    .VLenElems(VLenElems)
  ) i_dispatcher (
    .clk_i           (clk_i           ),
    .arst_n_i        (arst_n_i        ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .lane_cmd_o      (lane_cmd        ),
    .row_o           (row             ),
    .issue_o         (issue           ),
    .lane_rdata_i    (lane_rdata      )
  );

  // Lane l holds elements l, l + NrLanes, l + 2*NrLanes and so on
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes  (NrLanes  ),
      .VLenElems(VLenElems),
      .LaneId   (l        )
    ) i_lane (
      .clk_i     (clk_i        ),
      .arst_n_i  (arst_n_i     ),
      .lane_cmd_i(lane_cmd     ),
      .row_i     (row          ),
      .issue_i   (issue        ),
      .mask_bit_i(mask_bits[l] ),
      .cmp_o     (cmp[l]       ),
      .rdata_o   (lane_rdata[l])
    );
  end : gen_lanes

  vec_mask_unit #(
    .NrLanes  (NrLanes  ),
    .VLenElems(VLenElems)
  ) i_mask_unit (
    .clk_i      (clk_i    ),
    .arst_n_i   (arst_n_i ),
    .lane_cmd_i (lane_cmd ),
    .row_i      (row      ),
    .issue_i    (issue    ),
    .cmp_i      (cmp      ),
    .mask_bits_o(mask_bits)
  );

  // Parameter sanity
  if (NrLanes == 0 || NrLanes != 2 ** $clog2(NrLanes)) begin : gen_chk_lanes
    $error("vec_top: NrLanes must be a nonzero power of two");
  end

  if (NrLanes != 0 && (VLenElems % NrLanes) != 0) begin : gen_chk_vlen
    $error("vec_top: NrLanes must divide VLenElems");
  end

endmodule : vec_top

`default_nettype wire

// ==== tb/tb_vec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned VLenElems = 16;
  localparam int unsigned NrRows    = VLenElems / NrLanes;
  localparam int unsigned MaxStall  = 6;
  // Requests per test: 8 + 18 + 21 + 19 + 8
  localparam int unsigned NrReqs    = 74;
  localparam int unsigned MaxCycles = 2 * NrReqs * (NrRows + 2 + MaxStall) + 8;

  logic      clk_i;
  logic      arst_n_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  // Reference model state and the expected response
  elem_t                vrf_m [NrVRegs][VLenElems];
  logic [VLenElems-1:0] mask_m;
  elem_t                exp_data;
  logic                 exp_err;
  int unsigned          exp_r;

  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned test_err_base;
  int unsigned resp_cnt  = 0;
  int unsigned lat_cnt   = 0;
  int unsigned cycle_cnt = 0;

  vec_top i_dut (
    .clk_i           (clk_i           ),
    .arst_n_i        (arst_n_i        ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Cycles since the last acceptance edge, 1 in the first issue cycle
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (acc_req_valid_i && acc_req_ready_o) lat_cnt <= 1;
    else lat_cnt <= lat_cnt + 1;
    if (acc_resp_valid_o && acc_resp_ready_i) resp_cnt <= resp_cnt + 1;
  end

  always @(posedge clk_i) begin
    if (cycle_cnt >= MaxCycles) begin
      $display("Run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Response checks
  //////////////////////////////

  a_resp_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o && acc_resp_ready_i |-> acc_resp_o.data == exp_data)
  else begin
    $display("ERROR: acc_resp_o.data = %h, expected %h", $sampled(acc_resp_o.data),
             $sampled(exp_data));
    err_cnt++;
  end

  a_resp_error: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o && acc_resp_ready_i |-> acc_resp_o.error == exp_err)
  else begin
    $display("ERROR: acc_resp_o.error = %h, expected %h", $sampled(acc_resp_o.error),
             $sampled(exp_err));
    err_cnt++;
  end

  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(acc_resp_valid_o) |-> lat_cnt == exp_r + 1)
  else begin
    $display("ERROR: lat_cnt = %h, expected %h", $sampled(lat_cnt),
             $sampled(exp_r) + 1);
    err_cnt++;
  end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o))
  else begin
    $display("Response was dropped or changed while the core held it back");
    err_cnt++;
  end

  a_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o |-> !acc_req_ready_o)
  else begin
    $display("ERROR: acc_req_ready_o = %h, expected 0", $sampled(acc_req_ready_o));
    err_cnt++;
  end

  //////////////////////////////
  // Reference model and driver
  //////////////////////////////

  function automatic acc_req_t build_req(vec_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                         logic vm, elem_t scalar);
    acc_req_t r;
    r.op     = op;
    r.vd     = vd;
    r.vs1    = vs1;
    r.vs2    = vs2;
    r.vm     = vm;
    r.scalar = scalar;
    return r;
  endfunction

  task automatic model_apply(input acc_req_t req);
    begin
      exp_data = '0;
      exp_err  = 1'b0;
      exp_r    = NrRows;
      case (req.op)
        OP_VMV_VX, OP_VID, OP_VADD, OP_VSUB, OP_VAND: begin
          for (int i = 0; i < VLenElems; i++) begin
            if (!req.vm || mask_m[i]) begin
              case (req.op)
                OP_VMV_VX: vrf_m[req.vd][i] = req.scalar;
                OP_VID:    vrf_m[req.vd][i] = elem_t'(i);
                OP_VADD:   vrf_m[req.vd][i] = vrf_m[req.vs2][i] + vrf_m[req.vs1][i];
                OP_VSUB:   vrf_m[req.vd][i] = vrf_m[req.vs2][i] - vrf_m[req.vs1][i];
                default:   vrf_m[req.vd][i] = vrf_m[req.vs2][i] & vrf_m[req.vs1][i];
              endcase
            end
          end
        end
        OP_VMSEQ: begin
          for (int i = 0; i < VLenElems; i++) begin
            mask_m[i] = (vrf_m[req.vs2][i] == vrf_m[req.vs1][i]);
          end
        end
        OP_VMV_XS: begin
          exp_r    = 1;
          exp_data = vrf_m[req.vs2][req.scalar % VLenElems];
        end
        default: begin
          exp_r   = 1;
          exp_err = 1'b1;
        end
      endcase
    end
  endtask

  // One full request and response, the core stalls for stall cycles
  task automatic issue_request(input acc_req_t req, input int unsigned stall);
    begin
      @(negedge clk_i);
      model_apply(req);
      acc_req_i        = req;
      acc_req_valid_i  = 1'b1;
      acc_resp_ready_i = (stall == 0);
      @(negedge clk_i);
      acc_req_valid_i = 1'b0;
      while (!acc_resp_valid_o) @(negedge clk_i);
      repeat (stall) @(negedge clk_i);
      acc_resp_ready_i = 1'b1;
      @(negedge clk_i);
    end
  endtask

  task automatic read_elem(input vreg_t vs2, input elem_t idx, input int unsigned stall);
    issue_request(build_req(OP_VMV_XS, '0, '0, vs2, 1'b0, idx), stall);
  endtask

  task automatic report_test(input string name);
    begin
      test_cnt++;
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
      test_err_base = err_cnt;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    elem_t       k;
    int unsigned stall;
    void'($urandom(32'h288a_f1ea));
    arst_n_i         = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    mask_m           = '0;
    err_cnt          = 0;
    test_cnt         = 0;
    test_err_base    = 0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VLenElems; i++) vrf_m[r][i] = '0;
    end
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Idle handshake state, then every register reads zero
    @(negedge clk_i);
    assert (acc_req_ready_o === 1'b1) else begin
      $display("ERROR: acc_req_ready_o = %h, expected 1", acc_req_ready_o);
      err_cnt++;
    end
    assert (acc_resp_valid_o === 1'b0) else begin
      $display("ERROR: acc_resp_valid_o = %h, expected 0", acc_resp_valid_o);
      err_cnt++;
    end
    for (int r = 0; r < NrVRegs; r++) read_elem(vreg_t'(r), $urandom(), 0);
    report_test("reset state");

    issue_request(build_req(OP_VMV_VX, 3'd2, '0, '0, 1'b0, $urandom()), 0);
    repeat (8) read_elem(3'd2, $urandom(), 0);
    issue_request(build_req(OP_VID, 3'd1, '0, '0, 1'b0, '0), 0);
    repeat (8) read_elem(3'd1, $urandom(), 0);
    report_test("broadcast and index");

    issue_request(build_req(OP_VADD, 3'd3, 3'd1, 3'd2, 1'b0, '0), 0);
    issue_request(build_req(OP_VSUB, 3'd4, 3'd2, 3'd1, 1'b0, '0), 0);
    issue_request(build_req(OP_VAND, 3'd5, 3'd1, 3'd2, 1'b0, '0), 0);
    for (int r = 3; r <= 5; r++) begin
      repeat (6) read_elem(vreg_t'(r), $urandom(), 0);
    end
    report_test("integer ALU");

    // Only element k of v3 may change
    k = elem_t'($urandom_range(VLenElems - 1, 0));
    issue_request(build_req(OP_VMV_VX, 3'd6, '0, '0, 1'b0, k), 0);
    issue_request(build_req(OP_VMSEQ, 3'd0, 3'd1, 3'd6, 1'b0, '0), 0);
    issue_request(build_req(OP_VADD, 3'd3, 3'd1, 3'd6, 1'b1, '0), 0);
    for (int i = 0; i < VLenElems; i++) read_elem(3'd3, elem_t'(i), 0);
    report_test("compare and masked add");

    // Illegal opcodes target v3, which is read back afterwards
    repeat (4) begin
      stall = $urandom_range(MaxStall, 1);
      issue_request(build_req(vec_op_e'($urandom_range(15, 7)), 3'd3,
                              3'd1, 3'd2, 1'b0, $urandom()), stall);
    end
    repeat (4) read_elem(3'd3, $urandom(), $urandom_range(MaxStall, 1));
    report_test("illegal opcode and stalls");

    $display("%0d tests, %0d responses checked, %0d errors", test_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire
